// File: files.f
+incdir+hw
hw/mpadd_pkg.sv
hw/operand_shifter.sv
hw/step_carry_unit.sv
hw/result_collector.sv
hw/mpadd_control.sv
hw/mpadd_top.sv
test/mpadd_asserts.sv
test/mpadd_tb.sv

// File: run.sh
#!/bin/sh
# Builds the mpadd testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module mpadd_tb -f files.f -o mpadd_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/mpadd_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "test passed"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

// File: test/mpadd_stim.txt
// Columns: op (0 add, 1 sub) carry_in A B expected_sum expected_carry_out expected_overflow
// All values in hex, one request per line
0 0 0000000000000000 0000000000000000 0000000000000000 0 0
0 0 FFFFFFFFFFFFFFFF 0000000000000001 0000000000000000 1 0
0 1 FFFFFFFFFFFFFFFF 0000000000000000 0000000000000000 1 0
0 0 000000000000FFFF 0000000000000001 0000000000010000 0 0
0 0 00000000FFFFFFFF 0000000000000001 0000000100000000 0 0
0 0 0000FFFFFFFFFFFF 0000000000000001 0001000000000000 0 0
0 0 7FFFFFFFFFFFFFFF 0000000000000001 8000000000000000 0 1
0 0 8000000000000000 8000000000000000 0000000000000000 1 1
0 0 8000000000000000 FFFFFFFFFFFFFFFF 7FFFFFFFFFFFFFFF 1 1
0 0 0123456789ABCDEF 1111111111111111 123456789ABCDF00 0 0
0 1 FFFFFFFFFFFFFFFE 0000000000000001 0000000000000000 1 0
0 0 FFFF0000FFFF0000 0001000000010000 0000000100000000 1 0
0 0 4000000000000000 4000000000000000 8000000000000000 0 1
0 1 7FFFFFFFFFFFFFFF 0000000000000000 8000000000000000 0 1
0 0 DEADBEEFCAFEF00D 1234567890ABCDEF F0E215685BAABDFC 0 0
1 0 0000000000000005 0000000000000003 0000000000000002 1 0
1 1 0000000000000005 0000000000000003 0000000000000001 1 0
1 0 0000000000000000 0000000000000001 FFFFFFFFFFFFFFFF 0 0
1 1 0000000000000000 0000000000000000 FFFFFFFFFFFFFFFF 0 0
1 0 8000000000000000 0000000000000001 7FFFFFFFFFFFFFFF 1 1
1 1 8000000000000000 0000000000000000 7FFFFFFFFFFFFFFF 1 1
1 0 7FFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 8000000000000000 0 1
1 0 0000000000010000 0000000000000001 000000000000FFFF 1 0
1 0 0001000000000000 0000000000000001 0000FFFFFFFFFFFF 1 0
1 1 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0 0
1 0 1234567890ABCDEF 0123456789ABCDEF 1111111107000000 1 0
1 0 8000000000000000 7FFFFFFFFFFFFFFF 0000000000000001 1 1
1 0 0000000000000000 8000000000000000 8000000000000000 0 1

// File: test/mpadd_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiprecision adder/subtractor testbench
// Replays file vectors with random response stalls, checks sum, carries,
// carry-out, overflow and latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mpadd_defs.svh"

module mpadd_tb
    import mpadd_pkg::*;
();

    localparam int W           = `MP_WORD_WIDTH;
    localparam int STEP_COUNT  = `MP_STEP_COUNT;
    localparam int MAX_VECTORS = 64;
    localparam int FIELDS      = 7;

    logic        clock;
    logic        arst_n;
    mp_request_t req;
    logic        req_valid;
    logic        req_ready;
    mp_result_t  rsp;
    logic        rsp_valid;
    logic        rsp_ready;

    // Seven words per vector, in file column order
    logic [W-1:0] stim_words [0:MAX_VECTORS*FIELDS-1];

    int n_vectors;
    int error_count;
    int rsp_count;
    int cycle_count;
    int timeout_cycles;
    int pending_idx [$];
    int accept_edge [$];

    mpadd_top dut (
        .clock     (clock),
        .arst_n    (arst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    always #20 clock = ~clock;

    function automatic logic [W-1:0] vector_field(input int idx, input int f);
        return stim_words[idx * FIELDS + f];
    endfunction

    // Carries follow from A, B' and the expected sum
    function automatic mp_result_t expected_result(input int idx);
        mp_result_t   expected;
        logic [W-1:0] op_word;
        logic [W-1:0] flag_word;
        logic [W-1:0] b_eff;
        op_word            = vector_field(idx, 0);
        b_eff              = op_word[0] ? ~vector_field(idx, 3) : vector_field(idx, 3);
        expected.sum       = vector_field(idx, 4);
        flag_word          = vector_field(idx, 5);
        expected.carry_out = flag_word[0];
        flag_word          = vector_field(idx, 6);
        expected.overflow  = flag_word[0];
        expected.carries   = vector_field(idx, 2) ^ b_eff ^ expected.sum;
        return expected;
    endfunction

    // Address-tagged fill marks entries that the file does not reach
    task automatic load_vectors();
        for (int i = 0; i < MAX_VECTORS * FIELDS; i++) begin
            stim_words[i] = {32'hdead_beef, 32'(i)};
        end
        $readmemh("test/mpadd_stim.txt", stim_words);
        n_vectors = 0;
        while (n_vectors < MAX_VECTORS && stim_words[n_vectors * FIELDS] <= 1) begin
            n_vectors++;
        end
    endtask

    task automatic drive_request(input int idx);
        logic [W-1:0] op_word;
        logic [W-1:0] cin_word;
        op_word      = vector_field(idx, 0);
        cin_word     = vector_field(idx, 1);
        req.op       = op_word[0] ? OP_SUB : OP_ADD;
        req.carry_in = cin_word[0];
        req.a        = vector_field(idx, 2);
        req.b        = vector_field(idx, 3);
        req_valid    = 1'b1;
    endtask

    task automatic report_mismatch(input int idx, input string name,
                                   input logic [W-1:0] got, input logic [W-1:0] want);
        error_count++;
        $display("[FAIL] %0t: vector %0d %s is %h, expected %h", $time, idx, name, got, want);
    endtask

    task automatic check_response(input int idx);
        mp_result_t expected;
        expected = expected_result(idx);
        if (rsp.sum !== expected.sum) begin
            report_mismatch(idx, "sum", rsp.sum, expected.sum);
        end
        if (rsp.carries !== expected.carries) begin
            report_mismatch(idx, "carries", rsp.carries, expected.carries);
        end
        if (rsp.carry_out !== expected.carry_out) begin
            report_mismatch(idx, "carry_out", W'(rsp.carry_out), W'(expected.carry_out));
        end
        if (rsp.overflow !== expected.overflow) begin
            report_mismatch(idx, "overflow", W'(rsp.overflow), W'(expected.overflow));
        end
    endtask

    task automatic finish_run(input bit aborted);
        $display("Errors: %0d, responses: %0d of %0d", error_count, rsp_count, n_vectors);
        if (aborted || error_count != 0 || rsp_count != n_vectors) begin
            $display("test failed");
        end else begin
            $display("test passed");
        end
        $finish;
    endtask

    task automatic run_vectors();
        int         req_idx;
        int         cyc;
        int         stall_left;
        bit         rsp_seen;
        mp_result_t held_rsp;
        req_idx    = 0;
        cyc        = 0;
        stall_left = 0;
        rsp_seen   = 1'b0;
        held_rsp   = '0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        #1;
        if (rsp_valid !== 1'b0 || req_ready !== 1'b1 || rsp !== '0) begin
            error_count++;
            $display("[FAIL] %0t: outputs not idle after reset", $time);
        end
        while (rsp_count < n_vectors) begin
            @(negedge clock);
            cyc++;
            if (req_idx < n_vectors) begin
                drive_request(req_idx);
            end else begin
                req_valid = 1'b0;
            end
            // A new response rose on the previous edge
            if (rsp_valid && !rsp_seen) begin
                rsp_seen = 1'b1;
                held_rsp = rsp;
                if (pending_idx.size() == 0) begin
                    error_count++;
                    $display("Error at %0t: response with no request outstanding", $time);
                end else if (cyc - 1 - accept_edge[0] != STEP_COUNT) begin
                    error_count++;
                    $display("[FAIL] %0t: vector %0d latency %0d, expected %0d", $time,
                             pending_idx[0], cyc - 1 - accept_edge[0], STEP_COUNT);
                end
                // First few responses are taken at once to exercise back-to-back
                stall_left = (rsp_count < 4) ? 0 : int'($urandom % 8);
            end else if (rsp_valid && rsp !== held_rsp) begin
                error_count++;
                $display("[FAIL] %0t: rsp changed while stalled", $time);
            end
            rsp_ready = (stall_left == 0);
            if (stall_left > 0) begin
                stall_left--;
            end
            // Handshake signals are settled here and decide the transfers of the coming edge
            #1;
            if (req_valid && req_ready) begin
                pending_idx.push_back(req_idx);
                accept_edge.push_back(cyc);
                req_idx++;
            end
            if (rsp_valid && rsp_ready) begin
                if (pending_idx.size() > 0) begin
                    check_response(pending_idx[0]);
                    void'(pending_idx.pop_front());
                    void'(accept_edge.pop_front());
                end
                rsp_count++;
                rsp_seen = 1'b0;
            end
        end
        repeat (STEP_COUNT + 2) begin
            @(negedge clock);
            req_valid = 1'b0;
            if (rsp_valid !== 1'b0) begin
                error_count++;
                $display("Error at %0t: extra response after the last vector", $time);
            end
        end
    endtask

    // Watchdog on the total cycle count
    always @(posedge clock) begin
        cycle_count++;
        if (timeout_cycles > 0 && cycle_count >= timeout_cycles) begin
            $display("Timeout: run stopped after %0d cycles with %0d of %0d responses",
                     cycle_count, rsp_count, n_vectors);
            finish_run(1'b1);
        end
    end

    initial begin
        clock          = 1'b0;
        arst_n         = 1'b0;
        req            = '0;
        req_valid      = 1'b0;
        rsp_ready      = 1'b0;
        error_count    = 0;
        rsp_count      = 0;
        cycle_count    = 0;
        timeout_cycles = 0;
        void'($urandom(57923));
        load_vectors();
        if (n_vectors == 0) begin
            $display("No test vectors were read from test/mpadd_stim.txt");
            finish_run(1'b1);
        end else begin
            timeout_cycles = n_vectors * (STEP_COUNT + 10) + 50;
            run_vectors();
            finish_run(1'b0);
        end
    end

endmodule

// File: test/mpadd_asserts.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiprecision adder handshake assertions
// Reset state, response latency, back-pressure stability and busy ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mpadd_defs.svh"

module mpadd_asserts
    import mpadd_pkg::*;
(
    input logic       clock,
    input logic       arst_n,
    input logic       req_valid,
    input logic       req_ready,
    input mp_result_t rsp,
    input logic       rsp_valid,
    input logic       rsp_ready,
    input logic       step
);

    logic accept;

    assign accept = req_valid && req_ready;

    reset_idle: assert property (@(posedge clock)
        (!arst_n || $rose(arst_n)) |-> !rsp_valid)
        else $error("rsp_valid high during or right after reset");

    // Both checks count one extra cycle because sampled values lag the edge
    rise_after_accept: assert property (@(posedge clock) disable iff (!arst_n)
        $rose(rsp_valid) |-> $past(accept, `MP_STEP_COUNT + 1))
        else $error("rsp_valid rose without an accept the step count earlier");

    valid_after_accept: assert property (@(posedge clock) disable iff (!arst_n)
        $past(accept, `MP_STEP_COUNT + 1) |-> rsp_valid)
        else $error("rsp_valid missing the step count after an accept");

    hold_under_stall: assert property (@(posedge clock) disable iff (!arst_n)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
        else $error("Response changed or dropped while stalled");

    // Every cycle of the calculation after an accept steps and refuses requests
    for (genvar k = 1; k <= `MP_STEP_COUNT; k++) begin : g_busy
        busy_not_ready: assert property (@(posedge clock) disable iff (!arst_n)
            $past(accept, k) |-> (step && !req_ready))
            else $error("req_ready high or step missing while calculating");
    end

endmodule

bind mpadd_top mpadd_asserts u_asserts (
    .clock     (clock),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .step      (step)
);

// File: hw/mpadd_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiprecision signed adder/subtractor
// Computes A+B+carry_in or A-B-carry_in one step word per cycle, with
// sum, carry-out, per-bit carries and signed overflow
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mpadd_defs.svh"

module mpadd_top
    import mpadd_pkg::*;
(
    input  logic        clock,
    input  logic        arst_n,
    input  mp_request_t req,
    input  logic        req_valid,
    output logic        req_ready,
    output mp_result_t  rsp,
    output logic        rsp_valid,
    input  logic        rsp_ready
);

    logic                      load;
    logic                      step;
    logic [`MP_STEP_WIDTH-1:0] step_a;
    logic [`MP_STEP_WIDTH-1:0] step_b;
    mp_step_t                  step_out;
    logic                      carry;

    mpadd_control u_control (
        .clock     (clock),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .load      (load),
        .step      (step)
    );

    operand_shifter u_shifter (
        .clock  (clock),
        .arst_n (arst_n),
        .load   (load),
        .step   (step),
        .a      (req.a),
        .b      (req.b),
        .step_a (step_a),
        .step_b (step_b)
    );

    step_carry_unit u_carry_unit (
        .clock    (clock),
        .arst_n   (arst_n),
        .load     (load),
        .step     (step),
        .op       (req.op),
        .carry_in (req.carry_in),
        .step_a   (step_a),
        .step_b   (step_b),
        .step_out (step_out),
        .carry    (carry)
    );

    // Result registers hold steady in ST_DONE, so rsp is frozen there
    result_collector u_collector (
        .clock   (clock),
        .arst_n  (arst_n),
        .load    (load),
        .step    (step),
        .step_in (step_out),
        .carry   (carry),
        .result  (rsp)
    );

endmodule

// File: hw/mpadd_control.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiprecision adder control
// FSM and step counter behind the request and response handshakes,
// drives the datapath load and step strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mpadd_defs.svh"

module mpadd_control
    import mpadd_pkg::*;
(
    input  logic clock,
    input  logic arst_n,
    input  logic req_valid,
    output logic req_ready,
    output logic rsp_valid,
    input  logic rsp_ready,
    output logic load,
    output logic step
);

    `MP_CHECK_STEP_WIDTH

    localparam logic [`MP_STEP_CNT_WIDTH-1:0] STEP_LAST =
        (`MP_STEP_CNT_WIDTH)'(`MP_STEP_COUNT - 1);

    mp_state_e                     state;
    mp_state_e                     state_next;
    logic [`MP_STEP_CNT_WIDTH-1:0] step_cnt;
    logic                          last_step;

    // Handshakes
    assign rsp_valid = (state == ST_DONE);
    assign req_ready = (state == ST_LOAD) || ((state == ST_DONE) && rsp_ready);
    assign load      = req_valid && req_ready;
    assign step      = (state == ST_CALC);
    assign last_step = (step_cnt == '0);

    always_comb begin
        state_next = state;
        case (state)
            ST_LOAD: begin
                if (load) begin
                    state_next = ST_CALC;
                end
            end
            ST_CALC: begin
                if (last_step) begin
                    state_next = ST_DONE;
                end
            end
            ST_DONE: begin
                // Taking a result together with a new request reloads at once
                if (load) begin
                    state_next = ST_CALC;
                end else if (rsp_ready) begin
                    state_next = ST_LOAD;
                end
            end
            default: begin
                state_next = ST_LOAD;
            end
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_LOAD;
        end else begin
            state <= state_next;
        end
    end

    // Counts down the remaining steps, zero marks the last one
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            step_cnt <= '0;
        end else if (load) begin
            step_cnt <= STEP_LAST;
        end else if (step && !last_step) begin
            step_cnt <= step_cnt - 1'b1;
        end
    end

endmodule

// File: hw/result_collector.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result collector
// Shifts step sums and step carries into full width result registers and
// keeps the latest overflow and carry-out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mpadd_defs.svh"

module result_collector
    import mpadd_pkg::*;
(
    input  logic       clock,
    input  logic       arst_n,
    input  logic       load,
    input  logic       step,
    input  mp_step_t   step_in,
    input  logic       carry,
    output mp_result_t result
);

    // Words enter at the top, so the first step word ends up lowest
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (load) begin
            result <= '0;
        end else if (step) begin
            result.sum       <= {step_in.sum,
                                 result.sum[`MP_WORD_WIDTH-1:`MP_STEP_WIDTH]};
            result.carries   <= {step_in.carries,
                                 result.carries[`MP_WORD_WIDTH-1:`MP_STEP_WIDTH]};
            // Both are final once the top step word is done
            result.overflow  <= step_in.overflow;
            result.carry_out <= carry;
        end
    end

endmodule

// File: hw/step_carry_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Step carry unit
// Adds or subtracts one step word per cycle and keeps the running carry
// between steps, so the carry chain spans only one step word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mpadd_defs.svh"

module step_carry_unit
    import mpadd_pkg::*;
(
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      load,
    input  logic                      step,
    input  mp_op_e                    op,
    input  logic                      carry_in,
    input  logic [`MP_STEP_WIDTH-1:0] step_a,
    input  logic [`MP_STEP_WIDTH-1:0] step_b,
    output mp_step_t                  step_out,
    output logic                      carry
);

    mp_op_e                    op_q;
    logic                      carry_q;
    logic [`MP_STEP_WIDTH-1:0] b_eff;
    logic [`MP_STEP_WIDTH-1:0] sum_word;
    logic                      carry_next;

    // A subtract is A + ~B + ~carry_in
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            op_q    <= OP_ADD;
            carry_q <= 1'b0;
        end else if (load) begin
            op_q    <= op;
            carry_q <= (op == OP_SUB) ? ~carry_in : carry_in;
        end else if (step) begin
            carry_q <= carry_next;
        end
    end

    always_comb begin
        b_eff = (op_q == OP_SUB) ? ~step_b : step_b;
        {carry_next, sum_word} = {1'b0, step_a} + {1'b0, b_eff}
                               + {{`MP_STEP_WIDTH{1'b0}}, carry_q};
    end

    // Carry into each bit falls out of the sum bits
    always_comb begin
        step_out.sum      = sum_word;
        step_out.carries  = step_a ^ b_eff ^ sum_word;
        step_out.overflow = step_out.carries[`MP_STEP_WIDTH-1] ^ carry_next;
    end

    assign carry = carry_next;

endmodule

// File: hw/operand_shifter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand shifter
// Loads A and B in parallel, then presents one step word of each per
// cycle, least significant word first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mpadd_defs.svh"

module operand_shifter (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      load,
    input  logic                      step,
    input  logic [`MP_WORD_WIDTH-1:0] a,
    input  logic [`MP_WORD_WIDTH-1:0] b,
    output logic [`MP_STEP_WIDTH-1:0] step_a,
    output logic [`MP_STEP_WIDTH-1:0] step_b
);

    logic [`MP_WORD_WIDTH-1:0] a_shift;
    logic [`MP_WORD_WIDTH-1:0] b_shift;

    // Zero fill from the top as the words are consumed
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            a_shift <= '0;
            b_shift <= '0;
        end else if (load) begin
            a_shift <= a;
            b_shift <= b;
        end else if (step) begin
            a_shift <= {{`MP_STEP_WIDTH{1'b0}},
                        a_shift[`MP_WORD_WIDTH-1:`MP_STEP_WIDTH]};
            b_shift <= {{`MP_STEP_WIDTH{1'b0}},
                        b_shift[`MP_WORD_WIDTH-1:`MP_STEP_WIDTH]};
        end
    end

    // Current step operands sit in the low word
    assign step_a = a_shift[`MP_STEP_WIDTH-1:0];
    assign step_b = b_shift[`MP_STEP_WIDTH-1:0];

endmodule

// File: hw/mpadd_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiprecision adder/subtractor types
// Operation and state encodings, request, step and result records
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mpadd_defs.svh"

package mpadd_pkg;

    // Matches the sign bit convention: 0 adds, 1 subtracts
    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } mp_op_e;

    typedef enum logic [1:0] {
        ST_LOAD = 2'b00,
        ST_CALC = 2'b01,
        ST_DONE = 2'b11
    } mp_state_e;

    typedef struct packed {
        mp_op_e                    op;
        logic                      carry_in;
        logic [`MP_WORD_WIDTH-1:0] a;
        logic [`MP_WORD_WIDTH-1:0] b;
    } mp_request_t;

    // One step word worth of adder output
    typedef struct packed {
        logic [`MP_STEP_WIDTH-1:0] sum;
        logic [`MP_STEP_WIDTH-1:0] carries;
        logic                      overflow;
    } mp_step_t;

    typedef struct packed {
        logic [`MP_WORD_WIDTH-1:0] sum;
        logic [`MP_WORD_WIDTH-1:0] carries;
        logic                      carry_out;
        logic                      overflow;
    } mp_result_t;

endpackage

// File: hw/mpadd_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiprecision adder/subtractor sizing
// Word width, step word width and the step count derived from them
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MPADD_DEFS_SVH
`define MPADD_DEFS_SVH

`define MP_WORD_WIDTH 64
`define MP_STEP_WIDTH 16
`define MP_STEP_COUNT (`MP_WORD_WIDTH / `MP_STEP_WIDTH)
`define MP_STEP_CNT_WIDTH ((`MP_STEP_COUNT > 1) ? $clog2(`MP_STEP_COUNT) : 1)

// Elaboration check, expanded inside a module body
`define MP_CHECK_STEP_WIDTH \
    if ((`MP_WORD_WIDTH % `MP_STEP_WIDTH) != 0) begin : g_step_width_check \
        $error("Word width must be a whole multiple of the step width"); \
    end

`endif
